// ==== project.f ====
+incdir+test
hdl/clk_rst_pkg.sv
hdl/wb_fll_decoder.sv
hdl/fll_cfg_regs.sv
hdl/fll_divider.sv
hdl/rst_sync_gen.sv
hdl/fll_domain.sv
hdl/clk_rst_gen.sv
test/tb_clk_rst_gen.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the clk_rst_gen testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    -f project.f \
    --top-module tb_clk_rst_gen \
    -o sim_tb \
    > "$LOG" 2>&1 \
    && ./obj_dir/sim_tb >> "$LOG" 2>&1 \
    || { cat "$LOG"; echo "Build or simulation aborted"; exit 1; }

cat "$LOG"
grep -q "Test failed" "$LOG" && exit 1
grep -q "Test passed" "$LOG" || exit 1
exit 0

// ==== test/tb_ref_model.svh ====
// Testbench reference model; expects DIV_WIDTH, LOCK_TICKS, RST_STAGES, lfsr_q and err_cnt in scope

// Galois LFSR, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        lsb;
    val = '0;
    for (int i = 0; i < n; i++) begin
        lsb   = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (lsb) begin
            lfsr_q = lfsr_q ^ 32'h8020_0003;
        end
        val = {val[30:0], lsb};
    end
    return val;
endfunction

// Tick period in clk cycles, 0 when the FLL is off
function automatic int exp_period(input logic en, input logic [15:0] div);
    int d;
    d = int'(div) & ((1 << DIV_WIDTH) - 1);
    return (en && d != 0) ? d : 0;
endfunction

// Cycles from the write ack to the rise of lock
function automatic int exp_lock_cycles(input int div);
    return div * LOCK_TICKS;
endfunction

// Control word as read back, divisor bits above DIV_WIDTH are not stored
function automatic logic [31:0] exp_ctrl(input logic en, input logic [15:0] div);
    logic [31:0] w;
    w        = '0;
    w[0]     = en;
    w[31:16] = div & 16'((1 << DIV_WIDTH) - 1);
    return w;
endfunction

function automatic logic [31:0] exp_status(input logic lock);
    return {31'b0, lock};
endfunction

function automatic int exp_release_ticks();
    return RST_STAGES;
endfunction

task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("** Error: %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
        err_cnt++;
    end
endtask

// ==== test/tb_clk_rst_gen.sv ====
// Testbench for clk_rst_gen; divisors kept small (2..33) so runs stay short
`default_nettype none

module tb_clk_rst_gen;

    timeunit 1ns;
    timeprecision 1ps;

    import clk_rst_pkg::*;

    localparam int DIV_WIDTH   = 8;
    localparam int LOCK_TICKS  = 4;
    localparam int RST_STAGES  = 3;
    localparam int ACK_TIMEOUT = 50;
    localparam int TICK_TIMEOUT = 200;

    logic     clk;
    logic     rst_i;
    wb_req_t  wb_req;
    wb_rsp_t  wb_rsp;
    logic     sel_ref;
    logic     dbg_rst;
    dom_out_t soc_o;
    dom_out_t per_o;
    dom_out_t cluster_o;
    logic     glob_rst;

    logic [31:0] lfsr_q = 32'h17a5ef26;
    int          err_cnt = 0;
    int          timeout_cnt = 0;
    int          cyc = 0;
    int          period [3];
    int          last_tick [3];

    `include "tb_ref_model.svh"

    clk_rst_gen #(
        .DIV_WIDTH  (DIV_WIDTH),
        .LOCK_TICKS (LOCK_TICKS),
        .RST_STAGES (RST_STAGES)
    ) dut (
        .clk        (clk),
        .rst_i      (rst_i),
        .wb_req_i   (wb_req),
        .wb_rsp_o   (wb_rsp),
        .sel_ref_i  (sel_ref),
        .dbg_rst_i  (dbg_rst),
        .soc_o      (soc_o),
        .per_o      (per_o),
        .cluster_o  (cluster_o),
        .glob_rst_o (glob_rst)
    );

    always #10 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    function automatic dom_out_t dom_of(input int d);
        case (d)
            0:       return soc_o;
            1:       return per_o;
            default: return cluster_o;
        endcase
    endfunction

    // Tick spacing watcher, active once a period is set for a domain
    always @(negedge clk) begin
        dom_out_t o;
        for (int d = 0; d < 3; d++) begin
            o = dom_of(d);
            if (o.tick) begin
                if (period[d] != 0 && last_tick[d] >= 0) begin
                    check_eq($sformatf("dom%0d tick period", d), 32'(cyc - last_tick[d]),
                             32'(period[d]));
                end
                last_tick[d] = cyc;
            end
        end
    end

    task automatic set_period(input int d, input int p);
        period[d]    = p;
        last_tick[d] = -1;
    endtask

    // Returns on the posedge that drops the request; ack_cyc is the ack cycle
    task automatic wb_access(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat, output int ack_cyc);
        int n;
        n = 0;
        rdat = '0;
        ack_cyc = -1;
        @(posedge clk);
        wb_req.cyc <= 1'b1;
        wb_req.stb <= 1'b1;
        wb_req.we  <= we;
        wb_req.adr <= adr;
        wb_req.dat <= wdat;
        do begin
            @(negedge clk);
            n++;
        end while (!wb_rsp.ack && n < ACK_TIMEOUT);
        if (wb_rsp.ack) begin
            rdat    = wb_rsp.dat;
            ack_cyc = cyc;
        end else begin
            $display("Timeout: no Wishbone ack for address %0h", adr);
            timeout_cnt++;
        end
        @(posedge clk);
        wb_req <= '0;
    endtask

    task automatic wait_tick(input int d, output int at_cyc);
        int       n;
        dom_out_t o;
        n = 0;
        at_cyc = -1;
        do begin
            @(negedge clk);
            n++;
            o = dom_of(d);
        end while (!o.tick && n < TICK_TIMEOUT);
        if (o.tick) begin
            at_cyc = cyc;
        end else begin
            $display("Timeout: domain %0d produced no tick", d);
            timeout_cnt++;
        end
    endtask

    initial begin
        logic [31:0] rd;
        logic [15:0] div;
        logic        en;
        int          ack_c;
        int          t_c;
        int          d_val;
        dom_out_t    o;
        clk = 1'b0;
        rst_i = 1'b1;
        wb_req = '0;
        sel_ref = 1'b0;
        dbg_rst = 1'b0;
        for (int d = 0; d < 3; d++) set_period(d, 0);
        repeat (5) @(posedge clk);
        rst_i <= 1'b0;

        // Reset state
        @(negedge clk);
        for (int d = 0; d < 3; d++) begin
            o = dom_of(d);
            check_eq($sformatf("dom%0d tick", d), 32'(o.tick), 32'd0);
            check_eq($sformatf("dom%0d lock", d), 32'(o.lock), 32'd0);
            check_eq($sformatf("dom%0d rst", d), 32'(o.rst), 32'd1);
        end
        check_eq("glob_rst_o", 32'(glob_rst), 32'd1);
        check_eq("wb ack", 32'(wb_rsp.ack), 32'd0);
        for (int d = 0; d < 3; d++) begin
            wb_access(1'b0, 4'(d * 4), '0, rd, ack_c);
            check_eq($sformatf("dom%0d ctrl after reset", d), rd, 32'd0);
        end

        // Register access
        for (int d = 0; d < 3; d++) begin
            div = 16'(rand_bits(16));
            en  = 1'(rand_bits(1));
            wb_access(1'b1, 4'(d * 4), {div, 15'b0, en}, rd, ack_c);
            wb_access(1'b0, 4'(d * 4), '0, rd, ack_c);
            check_eq($sformatf("dom%0d ctrl readback", d), rd, exp_ctrl(en, div));
            wb_access(1'b1, 4'(d * 4), '0, rd, ack_c); // Back to off
        end
        for (int d = 0; d < 3; d++) begin
            wb_access(1'b1, 4'(d * 4 + 1), 32'hffff_ffff, rd, ack_c);
            wb_access(1'b0, 4'(d * 4 + 1), '0, rd, ack_c);
            check_eq($sformatf("dom%0d status", d), rd, exp_status(1'b0));
        end
        wb_access(1'b1, 4'hc, 32'hdead_beef, rd, ack_c);
        wb_access(1'b0, 4'hc, '0, rd, ack_c);
        check_eq("unmapped read", rd, 32'd0);

        // Divider timing, lock and reset release per domain
        for (int d = 0; d < 3; d++) begin
            div = 16'(rand_bits(5)) + 16'd2;
            d_val = exp_period(1'b1, div);
            wb_access(1'b1, 4'(d * 4), {div, 15'b0, 1'b1}, rd, ack_c);
            set_period(d, d_val);
            for (int k = 1; k <= RST_STAGES + 1 || k <= LOCK_TICKS; k++) begin
                wait_tick(d, t_c);
                o = dom_of(d);
                if (k == 1) begin
                    check_eq($sformatf("dom%0d first tick delay", d), 32'(t_c - ack_c),
                             32'(d_val));
                end
                if (k == LOCK_TICKS) begin
                    check_eq($sformatf("dom%0d lock time", d), 32'(t_c - ack_c),
                             32'(exp_lock_cycles(d_val)));
                end
                check_eq($sformatf("dom%0d lock", d), 32'(o.lock), 32'(k >= LOCK_TICKS));
                check_eq($sformatf("dom%0d rst", d), 32'(o.rst),
                         32'(k - 1 < exp_release_ticks()));
                if (d == 0) begin
                    check_eq("glob_rst_o", 32'(glob_rst), 32'(k - 1 < exp_release_ticks()));
                end
            end
            wb_access(1'b0, 4'(d * 4 + 1), '0, rd, ack_c);
            check_eq($sformatf("dom%0d status locked", d), rd, exp_status(1'b1));
            wb_access(1'b1, 4'(d * 4), '0, rd, ack_c);
            set_period(d, 0);
            @(negedge clk);
            o = dom_of(d);
            check_eq($sformatf("dom%0d lock after off", d), 32'(o.lock), 32'd0);
            check_eq($sformatf("dom%0d rst after off", d), 32'(o.rst), 32'd1);
        end

        // Reference bypass
        @(posedge clk);
        sel_ref <= 1'b1;
        for (int d = 0; d < 3; d++) set_period(d, 1);
        for (int n = 1; n <= RST_STAGES + 1; n++) begin
            @(negedge clk);
            for (int d = 0; d < 3; d++) begin
                o = dom_of(d);
                check_eq($sformatf("dom%0d rst bypass", d), 32'(o.rst),
                         32'(n <= exp_release_ticks()));
            end
        end
        div = 16'(rand_bits(5)) + 16'd2;
        wb_access(1'b1, 4'h8, {div, 15'b0, 1'b1}, rd, ack_c);
        repeat (8) @(negedge clk);

        // Debug reset pulse
        @(posedge clk);
        dbg_rst <= 1'b1;
        @(posedge clk);
        dbg_rst <= 1'b0;
        for (int n = 1; n <= RST_STAGES + 1; n++) begin
            @(negedge clk);
            check_eq("soc rst dbg", 32'(soc_o.rst), 32'(n <= exp_release_ticks()));
            check_eq("cluster rst dbg", 32'(cluster_o.rst), 32'(n <= exp_release_ticks()));
            check_eq("per rst dbg", 32'(per_o.rst), 32'd0);
            check_eq("glob_rst_o dbg", 32'(glob_rst), 32'd0);
        end
        @(posedge clk);
        sel_ref <= 1'b0;
        for (int d = 0; d < 3; d++) set_period(d, 0);
        repeat (2) @(posedge clk);

        $display("Checks done: %0d errors, %0d timeouts", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/clk_rst_gen.sv ====
// Clock/reset generator top; all domains are clock enables of clk, sel_ref_i bypasses every FLL
`default_nettype none

module clk_rst_gen #(
    parameter int DIV_WIDTH  = 8,
    parameter int LOCK_TICKS = 4,
    parameter int RST_STAGES = 3
) (
    input  logic                  clk,
    input  logic                  rst_i,
    input  clk_rst_pkg::wb_req_t  wb_req_i,
    output clk_rst_pkg::wb_rsp_t  wb_rsp_o,
    input  logic                  sel_ref_i,
    input  logic                  dbg_rst_i,
    output clk_rst_pkg::dom_out_t soc_o,
    output clk_rst_pkg::dom_out_t per_o,
    output clk_rst_pkg::dom_out_t cluster_o,
    output logic                  glob_rst_o
);

    import clk_rst_pkg::*;

    wb_req_t dom_req [NUM_DOM];
    wb_rsp_t dom_rsp [NUM_DOM];

    wb_fll_decoder i_dec (
        .clk       (clk),
        .rst_i     (rst_i),
        .wb_req_i  (wb_req_i),
        .wb_rsp_o  (wb_rsp_o),
        .dom_req_o (dom_req),
        .dom_rsp_i (dom_rsp)
    );

    fll_domain #(
        .DIV_WIDTH  (DIV_WIDTH),
        .LOCK_TICKS (LOCK_TICKS),
        .RST_STAGES (RST_STAGES),
        .USE_DBG    (1'b1)
    ) i_soc (
        .clk        (clk),
        .rst_i      (rst_i),
        .wb_req_i   (dom_req[DOM_SOC]),
        .wb_rsp_o   (dom_rsp[DOM_SOC]),
        .sel_ref_i  (sel_ref_i),
        .dbg_rst_i  (dbg_rst_i),
        .dom_o      (soc_o),
        .glob_rst_o (glob_rst_o)  // Global reset comes from the soc domain
    );

    fll_domain #(
        .DIV_WIDTH  (DIV_WIDTH),
        .LOCK_TICKS (LOCK_TICKS),
        .RST_STAGES (RST_STAGES),
        .USE_DBG    (1'b0)        // Peripherals survive a debug reset
    ) i_per (
        .clk        (clk),
        .rst_i      (rst_i),
        .wb_req_i   (dom_req[DOM_PER]),
        .wb_rsp_o   (dom_rsp[DOM_PER]),
        .sel_ref_i  (sel_ref_i),
        .dbg_rst_i  (dbg_rst_i),
        .dom_o      (per_o),
        .glob_rst_o ()
    );

    fll_domain #(
        .DIV_WIDTH  (DIV_WIDTH),
        .LOCK_TICKS (LOCK_TICKS),
        .RST_STAGES (RST_STAGES),
        .USE_DBG    (1'b1)
    ) i_cluster (
        .clk        (clk),
        .rst_i      (rst_i),
        .wb_req_i   (dom_req[DOM_CLUSTER]),
        .wb_rsp_o   (dom_rsp[DOM_CLUSTER]),
        .sel_ref_i  (sel_ref_i),
        .dbg_rst_i  (dbg_rst_i),
        .dom_o      (cluster_o),
        .glob_rst_o ()
    );

endmodule

`default_nettype wire

// ==== hdl/fll_domain.sv ====
// One clock domain; with USE_DBG = 0 the debug reset has no effect on the domain reset
`default_nettype none

module fll_domain #(
    parameter int DIV_WIDTH  = 8,
    parameter int LOCK_TICKS = 4,
    parameter int RST_STAGES = 3,
    parameter bit USE_DBG    = 1'b1
) (
    input  logic                  clk,
    input  logic                  rst_i,
    input  clk_rst_pkg::wb_req_t  wb_req_i,
    output clk_rst_pkg::wb_rsp_t  wb_rsp_o,
    input  logic                  sel_ref_i,
    input  logic                  dbg_rst_i,
    output clk_rst_pkg::dom_out_t dom_o,
    output logic                  glob_rst_o
);

    import clk_rst_pkg::*;

    fll_cfg_t cfg;
    logic     fll_tick;
    logic     fll_lock;
    logic     dom_tick;
    logic     no_src;   // Neither FLL nor reference drives the domain
    logic     dom_rst;

    fll_cfg_regs #(.DIV_WIDTH(DIV_WIDTH)) i_regs (
        .clk      (clk),
        .rst_i    (rst_i),
        .wb_req_i (wb_req_i),
        .wb_rsp_o (wb_rsp_o),
        .lock_i   (fll_lock),
        .cfg_o    (cfg)
    );

    fll_divider #(.DIV_WIDTH(DIV_WIDTH), .LOCK_TICKS(LOCK_TICKS)) i_fll (
        .clk    (clk),
        .rst_i  (rst_i),
        .cfg_i  (cfg),
        .tick_o (fll_tick),
        .lock_o (fll_lock)
    );

    assign dom_tick = sel_ref_i || fll_tick; // Reference bypass ticks every cycle
    assign no_src   = !sel_ref_i && !(cfg.en && (cfg.div[DIV_WIDTH-1:0] != '0));

    rst_sync_gen #(.RST_STAGES(RST_STAGES)) i_dom_rst (
        .clk       (clk),
        .rst_i     (rst_i),
        .src_rst_i (no_src || (USE_DBG && dbg_rst_i)),
        .tick_i    (dom_tick),
        .rst_o     (dom_rst)
    );

    // Debug-free copy, the global reset
    rst_sync_gen #(.RST_STAGES(RST_STAGES)) i_glob_rst (
        .clk       (clk),
        .rst_i     (rst_i),
        .src_rst_i (no_src),
        .tick_i    (dom_tick),
        .rst_o     (glob_rst_o)
    );

    assign dom_o.tick = dom_tick;
    assign dom_o.rst  = dom_rst;
    assign dom_o.lock = fll_lock;

endmodule

`default_nettype wire

// ==== hdl/rst_sync_gen.sv ====
// Domain reset synchronizer counted in domain ticks; RST_STAGES must be at least 2
`default_nettype none

module rst_sync_gen #(
    parameter int RST_STAGES = 3
) (
    input  logic clk,
    input  logic rst_i,
    input  logic src_rst_i,
    input  logic tick_i,
    output logic rst_o
);

    logic [RST_STAGES-1:0] sync_q; // Ones shift in toward release

    // Any reset clears the chain at once, release walks one stage per tick
    always_ff @(posedge clk) begin
        if (rst_i || src_rst_i) begin
            sync_q <= '0;
        end else if (tick_i) begin
            sync_q <= {sync_q[RST_STAGES-2:0], 1'b1};
        end
    end

    assign rst_o = !sync_q[RST_STAGES-1];

    // Release happens on a domain clock edge only
    a_release_on_tick: assert property (
        @(posedge clk) disable iff (rst_i) $fell(rst_o) |-> $past(tick_i)
    ) else $error("Domain reset released without a domain tick");

endmodule

`default_nettype wire

// ==== hdl/fll_divider.sv ====
// Behavioral FLL stand-in: one tick every D cycles of clk, lock after LOCK_TICKS ticks (>= 1)
`default_nettype none

module fll_divider #(
    parameter int DIV_WIDTH  = 8,
    parameter int LOCK_TICKS = 4
) (
    input  logic                  clk,
    input  logic                  rst_i,
    input  clk_rst_pkg::fll_cfg_t cfg_i,
    output logic                  tick_o,
    output logic                  lock_o
);

    localparam int CNT_W = $clog2(LOCK_TICKS + 1);

    logic [DIV_WIDTH-1:0] div;
    logic                 active;
    logic                 changed;
    logic                 en_q;
    logic [DIV_WIDTH-1:0] div_q;
    logic                 run_q;
    logic [DIV_WIDTH-1:0] cnt_q;      // Cycles left until the next tick
    logic [CNT_W-1:0]     tick_cnt_q;
    logic                 lock_q;
    logic                 lock_now;

    assign div     = cfg_i.div[DIV_WIDTH-1:0];
    assign active  = cfg_i.en && (div != '0); // Divisor 0 counts as off
    assign changed = (cfg_i.en != en_q) || (div != div_q);

    // A tick from the old setting is dropped in the cycle of a change
    assign tick_o   = run_q && (cnt_q == '0) && !changed;
    assign lock_now = tick_o && (tick_cnt_q == CNT_W'(LOCK_TICKS - 1));
    assign lock_o   = lock_q || lock_now;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            en_q       <= 1'b0;
            div_q      <= '0;
            run_q      <= 1'b0;
            cnt_q      <= '0;
            tick_cnt_q <= '0;
            lock_q     <= 1'b0;
        end else begin
            en_q  <= cfg_i.en;
            div_q <= div;
            if (changed) begin
                run_q      <= active;
                cnt_q      <= div - 1'b1; // First tick D cycles after the change
                tick_cnt_q <= '0;
                lock_q     <= 1'b0;
            end else begin
                if (run_q) begin
                    cnt_q <= (cnt_q == '0) ? div_q - 1'b1 : cnt_q - 1'b1;
                end
                if (tick_o && !lock_q) begin
                    tick_cnt_q <= tick_cnt_q + 1'b1;
                end
                if (lock_now) begin
                    lock_q <= 1'b1;
                end
            end
        end
    end

    a_no_tick_when_off: assert property (
        @(posedge clk) disable iff (rst_i) tick_o |-> active
    ) else $error("FLL tick while disabled");

endmodule

`default_nettype wire

// ==== hdl/fll_cfg_regs.sv ====
// FLL register block; DIV_WIDTH must not exceed 16, divisor bits above DIV_WIDTH read as zero
`default_nettype none

module fll_cfg_regs #(
    parameter int DIV_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  rst_i,
    input  clk_rst_pkg::wb_req_t  wb_req_i,
    output clk_rst_pkg::wb_rsp_t  wb_rsp_o,
    input  logic                  lock_i,
    output clk_rst_pkg::fll_cfg_t cfg_o
);

    import clk_rst_pkg::*;

    logic                 req;
    logic                 start;       // First cycle of a new access
    logic                 ack_q;
    logic [31:0]          rd_mux;
    logic [31:0]          rdata_q;
    logic                 ctrl_en_q;
    logic [DIV_WIDTH-1:0] ctrl_div_q;

    assign req   = wb_req_i.cyc && wb_req_i.stb;
    assign start = req && !ack_q;

    always_comb begin
        rd_mux = '0;
        case (wb_req_i.adr[1:0])
            REG_CTRL: begin
                rd_mux[0]                         = ctrl_en_q;
                rd_mux[CTRL_DIV_LSB +: DIV_WIDTH] = ctrl_div_q;
            end
            REG_STATUS: rd_mux[0] = lock_i;
            default:    rd_mux    = '0; // Unused offsets
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q      <= 1'b0;
            ctrl_en_q  <= 1'b0;
            ctrl_div_q <= '0;
        end else begin
            ack_q <= start; // Never twice in a row
            if (start && wb_req_i.we && (wb_req_i.adr[1:0] == REG_CTRL)) begin
                ctrl_en_q  <= wb_req_i.dat[0];
                ctrl_div_q <= wb_req_i.dat[CTRL_DIV_LSB +: DIV_WIDTH];
            end
        end
    end

    // Held at zero outside an ack so the decoder can OR the blocks
    always_ff @(posedge clk) begin
        rdata_q <= start ? rd_mux : '0;
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = rdata_q;

    always_comb begin
        cfg_o                   = '0;
        cfg_o.en                = ctrl_en_q;
        cfg_o.div[DIV_WIDTH-1:0] = ctrl_div_q;
    end

    // Classic master keeps request, address and direction until ack
    a_req_held: assert property (
        @(posedge clk) disable iff (rst_i)
        start |=> req && $stable(wb_req_i.adr) && $stable(wb_req_i.we)
    ) else $error("Wishbone request changed before ack");

endmodule

`default_nettype wire

// ==== hdl/wb_fll_decoder.sv ====
// Wishbone classic splitter for three FLL register blocks; domain 3 is acked here and reads zero
`default_nettype none

module wb_fll_decoder (
    input  logic                  clk,
    input  logic                  rst_i,
    input  clk_rst_pkg::wb_req_t  wb_req_i,
    output clk_rst_pkg::wb_rsp_t  wb_rsp_o,
    output clk_rst_pkg::wb_req_t  dom_req_o [clk_rst_pkg::NUM_DOM],
    input  clk_rst_pkg::wb_rsp_t  dom_rsp_i [clk_rst_pkg::NUM_DOM]
);

    import clk_rst_pkg::*;

    logic               unm_req;
    logic               unm_ack_q;
    logic [NUM_DOM-1:0] dom_ack;

    // Strobe reaches only the addressed block
    always_comb begin
        for (int i = 0; i < NUM_DOM; i++) begin
            dom_req_o[i]     = wb_req_i;
            dom_req_o[i].stb = wb_req_i.stb && (wb_req_i.adr[3:2] == 2'(i));
        end
    end

    assign unm_req = wb_req_i.cyc && wb_req_i.stb && (wb_req_i.adr[3:2] == DOM_NONE);

    // Same single-cycle ack rule as the register blocks
    always_ff @(posedge clk) begin
        if (rst_i) begin
            unm_ack_q <= 1'b0;
        end else begin
            unm_ack_q <= unm_req && !unm_ack_q;
        end
    end

    // Idle blocks return zero data, so a plain OR merges the responses
    always_comb begin
        wb_rsp_o.ack = unm_ack_q;
        wb_rsp_o.dat = '0;
        for (int i = 0; i < NUM_DOM; i++) begin
            dom_ack[i]   = dom_rsp_i[i].ack;
            wb_rsp_o.ack = wb_rsp_o.ack | dom_rsp_i[i].ack;
            wb_rsp_o.dat = wb_rsp_o.dat | dom_rsp_i[i].dat;
        end
    end

    // Only one responder per cycle, otherwise the OR merge corrupts read data
    a_single_ack: assert property (
        @(posedge clk) disable iff (rst_i) $onehot0({unm_ack_q, dom_ack})
    ) else $error("More than one Wishbone responder acknowledged");

endmodule

`default_nettype wire

// ==== hdl/clk_rst_pkg.sv ====
// Shared types for the clock/reset generator; divisor fields are sized for DIV_W_MAX = 16 bits
`default_nettype none

package clk_rst_pkg;

    localparam int DIV_W_MAX    = 16; // Upper bound for the DIV_WIDTH parameter
    localparam int NUM_DOM      = 3;
    localparam int CTRL_DIV_LSB = 16; // Divisor position in the control word

    // Domain select, address bits 3:2
    localparam logic [1:0] DOM_SOC     = 2'd0;
    localparam logic [1:0] DOM_PER     = 2'd1;
    localparam logic [1:0] DOM_CLUSTER = 2'd2;
    localparam logic [1:0] DOM_NONE    = 2'd3; // Unmapped, reads zero

    // Register select, address bits 1:0
    localparam logic [1:0] REG_CTRL   = 2'd0; // Bit 0 enable, bits 31:16 divisor
    localparam logic [1:0] REG_STATUS = 2'd1; // Bit 0 lock, read-only

    // Wishbone classic request, 39 bits
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr; // Word address
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat; // Zero whenever ack is low
    } wb_rsp_t;

    typedef struct packed {
        logic                 en;
        logic [DIV_W_MAX-1:0] div; // Only the low DIV_WIDTH bits are live
    } fll_cfg_t;

    typedef struct packed {
        logic tick; // One-cycle clock enable
        logic rst;  // Active high, released on domain ticks
        logic lock;
    } dom_out_t;

endpackage

`default_nettype wire
